/* hw/navre_pkg.sv */
// Navre core package with the shared widths, word types and FSM encodings.
`default_nettype none

package navre_pkg;

	// --------------------
	// Default widths.
	// --------------------
	parameter int PMEM_WIDTH_DEF = 10; // Program word address bits.
	parameter int DMEM_WIDTH_DEF = 10; // Data byte address bits.

	// --------------------
	// Word types.
	// --------------------
	typedef logic [7:0]  byte_t;    // Register, RAM and I/O data.
	typedef logic [15:0] insn_t;    // One instruction word.
	typedef logic [4:0]  reg_idx_t; // r0 to r31.
	typedef logic [5:0]  io_addr_t; // 64 I/O locations.

	// ALU operations; pass forwards operand b.
	typedef enum logic [2:0] {
		op_pass, // MOV and LDI.
		op_add,
		op_adc,
		op_sub,
		op_and,
		op_or,
		op_eor
	} alu_op_t;

	typedef enum logic [3:0] {
		cls_nop,    // Also every unknown opcode.
		cls_alu,    // Two-register operations.
		cls_ldi,    // Immediate into r16..r31.
		cls_ld,     // Load through Z.
		cls_st,     // Store through Z.
		cls_in,     // I/O read.
		cls_out,    // I/O write.
		cls_rjmp,   // Relative jump.
		cls_branch  // BREQ or BRNE.
	} insn_class_t;

	typedef enum logic [1:0] {
		state_fetch,    // Program memory read.
		state_exec,     // Execute and write back.
		state_load_wait // Write back of LD and IN.
	} core_state_t;

endpackage

`default_nettype wire

/* hw/navre_alu.sv */
// Navre ALU, computes the 8-bit result and the new Z and C flags.
`default_nettype none

module navre_alu import navre_pkg::*; (
	input  wire alu_op_t op,     // Operation select.
	input  wire byte_t   a,      // Rd operand.
	input  wire byte_t   b,      // Rr or immediate operand.
	input  wire          c_in,   // Current carry flag.
	output byte_t        result, // Value for Rd.
	output logic         z_out,  // Result is zero.
	output logic         c_out   // New carry or borrow.
);

	logic [8:0] sum; // Ninth bit holds carry out or borrow.

	// --------------------
	// Operation mux.
	// --------------------
	always_comb begin
		sum    = 9'd0;
		result = b;    // Pass by default.
		c_out  = c_in; // Carry kept unless arithmetic.
		case (op)
			op_pass: begin
				result = b; // Straight copy.
			end
			op_add: begin
				sum    = {1'b0, a} + {1'b0, b};
				result = sum[7:0];
				c_out  = sum[8]; // Carry out of bit 7.
			end
			op_adc: begin
				sum    = {1'b0, a} + {1'b0, b} + {8'd0, c_in};
				result = sum[7:0];
				c_out  = sum[8];
			end
			op_sub: begin
				sum    = {1'b0, a} - {1'b0, b};
				result = sum[7:0];
				c_out  = sum[8]; // Set when b is larger than a.
			end
			op_and: begin
				result = a & b;
			end
			op_or: begin
				result = a | b;
			end
			op_eor: begin
				result = a ^ b;
			end
			default: begin
				result = b;
			end
		endcase
	end

	// Zero flag follows the result for every operation.
	assign z_out = (result == 8'h00);

endmodule

`default_nettype wire

/* hw/navre_decode.sv */
// Navre instruction decoder, splits an AVR word into fields and a control class.
`default_nettype none

module navre_decode import navre_pkg::*; (
	input  wire insn_t          insn,          // Word from program memory.
	output insn_class_t         insn_class,    // Control class.
	output alu_op_t             op,            // ALU operation.
	output reg_idx_t            rd,            // Destination register.
	output reg_idx_t            rr,            // Source register.
	output byte_t               imm,           // LDI constant.
	output io_addr_t            io_a,          // IN and OUT address.
	output logic signed [11:0]  offset,        // Word offset for jumps.
	output logic                branch_on_set  // Branch when Z is set.
);

	// --------------------
	// Field extraction.
	// --------------------
	// Fields are cut the same way for every word, the class decides use.
	assign imm  = {insn[11:8], insn[3:0]}; // KKKK from both nibbles.
	assign io_a = {insn[10:9], insn[3:0]}; // AA AAAA.

	// BREQ has bit 10 clear, BRNE has it set.
	assign branch_on_set = ~insn[10];

	// --------------------
	// Opcode match.
	// --------------------
	always_comb begin
		insn_class = cls_nop;
		op         = op_pass;
		rd         = insn[8:4];               // ddddd.
		rr         = {insn[9], insn[3:0]};    // r rrrr.
		offset     = 12'sd0;
		casez (insn)
			16'b0000_11??_????_????: begin // ADD.
				insn_class = cls_alu;
				op         = op_add;
			end
			16'b0001_11??_????_????: begin // ADC.
				insn_class = cls_alu;
				op         = op_adc;
			end
			16'b0001_10??_????_????: begin // SUB.
				insn_class = cls_alu;
				op         = op_sub;
			end
			16'b0010_00??_????_????: begin // AND.
				insn_class = cls_alu;
				op         = op_and;
			end
			16'b0010_01??_????_????: begin // EOR.
				insn_class = cls_alu;
				op         = op_eor;
			end
			16'b0010_10??_????_????: begin // OR.
				insn_class = cls_alu;
				op         = op_or;
			end
			16'b0010_11??_????_????: begin // MOV, flags untouched.
				insn_class = cls_alu;
				op         = op_pass;
			end
			16'b1110_????_????_????: begin // LDI, upper half only.
				insn_class = cls_ldi;
				rd         = {1'b1, insn[7:4]};
			end
			16'b1000_000?_????_0000: begin // LD Rd,Z.
				insn_class = cls_ld;
			end
			16'b1000_001?_????_0000: begin // ST Z,Rr.
				insn_class = cls_st;
				rr         = insn[8:4]; // Source sits in the d slot.
			end
			16'b1011_0???_????_????: begin // IN.
				insn_class = cls_in;
			end
			16'b1011_1???_????_????: begin // OUT.
				insn_class = cls_out;
				rr         = insn[8:4];
			end
			16'b1100_????_????_????: begin // RJMP, 12-bit offset.
				insn_class = cls_rjmp;
				offset     = insn[11:0];
			end
			16'b1111_0???_????_?001: begin // BREQ and BRNE on bit 1 (Z).
				insn_class = cls_branch;
				offset     = {{5{insn[9]}}, insn[9:3]}; // Sign extend k.
			end
			default: begin
				insn_class = cls_nop; // NOP and the rest of the ISA.
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/navre_core.sv */
// Navre core with register file, program counter, flags and fetch/execute FSM.
`default_nettype none

module navre_core import navre_pkg::*; #(
	parameter int pmem_width = PMEM_WIDTH_DEF, // Program word address bits.
	parameter int dmem_width = DMEM_WIDTH_DEF  // Data byte address bits.
) (
	input  wire                    sys_clk,
	input  wire                    sys_rst,  // Active low.
	output logic                   pmem_ce,  // Program read strobe.
	output logic [pmem_width-1:0]  pmem_a,
	input  wire insn_t             pmem_d,   // Valid one edge after pmem_ce.
	output logic                   dmem_we,
	output logic [dmem_width-1:0]  dmem_a,
	output byte_t                  dmem_do,
	input  wire byte_t             dmem_di,  // Registered RAM read.
	output logic                   io_re,
	output logic                   io_we,
	output io_addr_t               io_a,
	output byte_t                  io_do,
	input  wire byte_t             io_di     // Valid one edge after io_re.
);

	core_state_t            state;
	logic [pmem_width-1:0]  pc;
	logic [pmem_width-1:0]  pc_inc;     // pc + 1.
	logic [pmem_width-1:0]  offset_ext; // Offset at pc width.
	logic                   flag_z;
	logic                   flag_c;
	byte_t                  regs [0:31];

	insn_class_t            insn_class;
	alu_op_t                op;
	reg_idx_t               rd;
	reg_idx_t               rr;
	byte_t                  imm;
	logic signed [11:0]     offset;
	logic                   branch_on_set;

	byte_t                  alu_b;
	byte_t                  alu_result;
	logic                   alu_z;
	logic                   alu_c;

	logic                   in_exec;
	logic                   needs_wait;   // LD and IN take a third cycle.
	logic                   jump;         // RJMP or taken branch.
	logic                   flag_we;
	logic                   reg_we;
	byte_t                  reg_wdata;
	logic [15:0]            z_ptr;        // r31:r30.

	// --------------------
	// Decode and ALU.
	// --------------------
	navre_decode u_decode (
		.insn          (pmem_d),
		.insn_class    (insn_class),
		.op            (op),
		.rd            (rd),
		.rr            (rr),
		.imm           (imm),
		.io_a          (io_a),
		.offset        (offset),
		.branch_on_set (branch_on_set)
	);

	assign alu_b = (insn_class == cls_ldi) ? imm : regs[rr]; // LDI goes through pass.

	navre_alu u_alu (
		.op     (op),
		.a      (regs[rd]),
		.b      (alu_b),
		.c_in   (flag_c),
		.result (alu_result),
		.z_out  (alu_z),
		.c_out  (alu_c)
	);

	// --------------------
	// Control decode.
	// --------------------
	assign in_exec    = (state == state_exec);
	assign needs_wait = (insn_class == cls_ld) || (insn_class == cls_in);
	assign jump       = (insn_class == cls_rjmp) ||
	                    ((insn_class == cls_branch) && (flag_z == branch_on_set));
	assign flag_we    = in_exec && (insn_class == cls_alu) && (op != op_pass); // Not MOV.

	assign pc_inc     = pc + {{(pmem_width-1){1'b0}}, 1'b1};
	assign offset_ext = pmem_width'(offset); // Sign extends or wraps.

	// Memory and I/O strobes, one cycle each in exec.
	assign pmem_ce = (state == state_fetch);
	assign pmem_a  = pc;
	assign z_ptr   = {regs[31], regs[30]};
	assign dmem_a  = z_ptr[dmem_width-1:0]; // Also the LD read address.
	assign dmem_we = in_exec && (insn_class == cls_st);
	assign dmem_do = regs[rr];
	assign io_re   = in_exec && (insn_class == cls_in);
	assign io_we   = in_exec && (insn_class == cls_out);
	assign io_do   = regs[rr];

	// --------------------
	// Register file.
	// --------------------
	assign reg_we = (in_exec && ((insn_class == cls_alu) || (insn_class == cls_ldi))) ||
	                (state == state_load_wait);

	always_comb begin
		reg_wdata = alu_result;
		if (state == state_load_wait)
			reg_wdata = (insn_class == cls_in) ? io_di : dmem_di; // Late data.
	end

	always_ff @(posedge sys_clk) begin
		if (reg_we)
			regs[rd] <= reg_wdata;
	end

	// --------------------
	// FSM, pc and flags.
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (!sys_rst) begin
			state  <= state_fetch;
			pc     <= '0;
			flag_z <= 1'b0;
			flag_c <= 1'b0;
		end else begin
			case (state)
				state_fetch: begin
					state <= state_exec; // Word arrives on this edge.
				end
				state_exec: begin
					state <= needs_wait ? state_load_wait : state_fetch;
					pc    <= jump ? (pc_inc + offset_ext) : pc_inc;
					if (flag_we) begin
						flag_z <= alu_z;
						flag_c <= alu_c;
					end
				end
				state_load_wait: begin
					state <= state_fetch;
				end
				default: begin
					state <= state_fetch;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/navre_dmem.sv */
// Navre data RAM, a single-port byte array with a registered read.
`default_nettype none

module navre_dmem import navre_pkg::*; #(
	parameter int dmem_width = DMEM_WIDTH_DEF // Byte address bits.
) (
	input  wire                    sys_clk,
	input  wire                    we,   // Write strobe.
	input  wire [dmem_width-1:0]   a,    // Byte address.
	input  wire byte_t             di,   // Write data.
	output byte_t                  dout  // Read data, one cycle late.
);

	byte_t mem [0:(1 << dmem_width)-1];

	// Read before write on the same address.
	always_ff @(posedge sys_clk) begin
		if (we)
			mem[a] <= di;
		dout <= mem[a]; // Read every edge.
	end

endmodule

`default_nettype wire

/* hw/navre_system.sv */
// Navre system top, the core with its data RAM and external program and I/O ports.
`default_nettype none

module navre_system import navre_pkg::*; #(
	parameter int pmem_width = PMEM_WIDTH_DEF,
	parameter int dmem_width = DMEM_WIDTH_DEF
) (
	input  wire                    sys_clk,
	input  wire                    sys_rst,  // Active low.
	output logic                   pmem_ce,
	output logic [pmem_width-1:0]  pmem_a,
	input  wire insn_t             pmem_d,
	output logic                   io_re,
	output logic                   io_we,
	output io_addr_t               io_a,
	output byte_t                  io_do,
	input  wire byte_t             io_di
);

	logic                   dmem_we;
	logic [dmem_width-1:0]  dmem_a;
	byte_t                  dmem_do; // Core to RAM.
	byte_t                  dmem_di; // RAM to core.

	navre_core #(
		.pmem_width (pmem_width),
		.dmem_width (dmem_width)
	) u_core (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.pmem_ce (pmem_ce),
		.pmem_a  (pmem_a),
		.pmem_d  (pmem_d),
		.dmem_we (dmem_we),
		.dmem_a  (dmem_a),
		.dmem_do (dmem_do),
		.dmem_di (dmem_di),
		.io_re   (io_re),
		.io_we   (io_we),
		.io_a    (io_a),
		.io_do   (io_do),
		.io_di   (io_di)
	);

	navre_dmem #(
		.dmem_width (dmem_width)
	) u_dmem (
		.sys_clk (sys_clk),
		.we      (dmem_we),
		.a       (dmem_a),
		.di      (dmem_do),
		.dout    (dmem_di)
	);

endmodule

`default_nettype wire

/* test/navre_checker.sv */
// Navre checker that runs an instruction-set model and compares I/O writes and reset state.
`default_nettype none

module navre_checker import navre_pkg::*; (
	input  wire              sys_clk,
	input  wire              sys_rst,
	input  wire              pmem_ce,
	input  wire [9:0]        pmem_a,
	input  wire              io_re,
	input  wire              io_we,
	input  wire io_addr_t    io_a,
	input  wire byte_t       io_do
);

	insn_t    prog [0:1023];    // Copy of the program.
	io_addr_t exp_a [0:4095];   // Expected OUT addresses.
	byte_t    exp_d [0:4095];   // Expected OUT values.
	int       exp_n;
	int       write_count;      // Writes seen in this test.
	int       test_errors;
	int       pass_count = 0;
	int       fail_count = 0;
	string    test_name = "none";
	logic     rst_prev = 1'b1;

	task automatic load_word(input int addr, input insn_t w);
		prog[addr] = w;
	endtask

	// --------------------
	// Instruction-set model.
	// --------------------
	task automatic start_test(input string name, output int count);
		byte_t             r [0:31];
		byte_t             m [0:1023];
		logic              z;
		logic              c;
		int                pc;
		int                steps;
		int                d;
		int                rr;
		insn_t             w;
		logic [8:0]        s;
		logic [9:0]        za;
		logic signed [11:0] k;
		test_name   = name;
		test_errors = 0;
		write_count = 0;
		z = 1'b0; // Flags clear after reset.
		c = 1'b0;
		pc = 0;
		steps = 0;
		count = 0;
		while (prog[pc] != 16'hCFFF && steps < 20000) begin
			w  = prog[pc];
			pc = (pc + 1) & 1023;
			steps++;
			d  = w[8:4];
			rr = {w[9], w[3:0]};
			za = {r[31][1:0], r[30]}; // Z truncated to 10 bits.
			k  = 12'sd0;
			s  = 9'd0;
			casez (w)
				16'b0000_11??_????_????: s = {1'b0, r[d]} + {1'b0, r[rr]};
				16'b0001_11??_????_????: s = {1'b0, r[d]} + {1'b0, r[rr]} + {8'd0, c};
				16'b0001_10??_????_????: s = {1'b0, r[d]} - {1'b0, r[rr]}; // Borrow in s[8].
				16'b0010_00??_????_????: r[d] = r[d] & r[rr];
				16'b0010_01??_????_????: r[d] = r[d] ^ r[rr];
				16'b0010_10??_????_????: r[d] = r[d] | r[rr];
				16'b0010_11??_????_????: r[d] = r[rr]; // MOV keeps flags.
				16'b1110_????_????_????: r[{1'b1, w[7:4]}] = {w[11:8], w[3:0]};
				16'b1000_000?_????_0000: r[d] = m[za];
				16'b1000_001?_????_0000: m[za] = r[d];
				16'b1011_0???_????_????: r[d] = {2'b00, w[10:9], w[3:0]} ^ 8'h5A;
				16'b1011_1???_????_????: begin
					exp_a[count] = {w[10:9], w[3:0]};
					exp_d[count] = r[d];
					count++;
				end
				16'b1100_????_????_????: k = w[11:0];
				16'b1111_0???_????_?001: begin
					if (z == ~w[10]) // BREQ on set, BRNE on clear.
						k = {{5{w[9]}}, w[9:3]};
				end
				default: ;
			endcase
			// Arithmetic results and flags.
			if (w[15:12] == 4'h0 && w[11:10] == 2'b11 ||
			    w[15:12] == 4'h1 && w[11] == 1'b1) begin
				r[d] = s[7:0];
				c    = s[8];
			end
			if (w[15:12] <= 4'h2 && w[15:10] != 6'b001011 && w[15:10] != 6'b000000)
				z = (r[d] == 8'h00);
			pc = (pc + int'(k)) & 1023;
		end
		if (steps >= 20000) begin
			$display("%s: model never reached the final jump", name);
			test_errors++;
		end
		exp_n = count;
	endtask

	task automatic end_test(input logic timed_out);
		if (test_errors == 0 && !timed_out) begin
			pass_count++;
			$display("PASS %s (%0d writes)", test_name, write_count);
		end else begin
			fail_count++;
			$display("FAIL %s (%0d errors)", test_name, test_errors);
		end
	endtask

	task automatic final_report();
		$display("Tests: %0d passed, %0d failed", pass_count, fail_count);
	endtask

	// --------------------
	// Port monitor.
	// --------------------
	always @(posedge sys_clk) begin
		if (!rst_prev && (io_we !== 1'b0 || io_re !== 1'b0)) begin
			$display("%s: I/O strobe active during or right after reset", test_name);
			test_errors++;
		end
		if (sys_rst && !rst_prev && (pmem_ce !== 1'b1 || pmem_a !== 10'd0)) begin
			$display("%s: first fetch after reset is not at address 0", test_name);
			test_errors++;
		end
		if (sys_rst && io_we === 1'b1) begin
			if (write_count >= exp_n) begin
				$display("%s: unexpected I/O write to %h", test_name, io_a);
				test_errors++;
			end else if (io_a !== exp_a[write_count] || io_do !== exp_d[write_count]) begin
				$display("ERROR %s write %0d: expected %h:%h actual %h:%h", test_name,
				         write_count, exp_a[write_count], exp_d[write_count], io_a, io_do);
				test_errors++;
			end
			write_count++;
		end
		rst_prev <= sys_rst;
	end

endmodule

`default_nettype wire

/* test/tb_navre.sv */
// Navre testbench with program memory, I/O responder and random program generator.
`default_nettype none

module tb_navre;

	logic        sys_clk;
	logic        sys_rst;
	logic        pmem_ce;
	logic [9:0]  pmem_a;
	logic [15:0] pmem_d;
	logic        io_re;
	logic        io_we;
	logic [5:0]  io_a;
	logic [7:0]  io_do;
	logic [7:0]  io_di;
	logic [15:0] prog [0:1023]; // Program memory.
	logic [15:0] lfsr;
	logic [9:0]  st_addr [0:7];
	int          prog_len;

	navre_system #(.pmem_width(10), .dmem_width(10)) dut (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .pmem_ce(pmem_ce), .pmem_a(pmem_a),
		.pmem_d(pmem_d), .io_re(io_re), .io_we(io_we), .io_a(io_a), .io_do(io_do),
		.io_di(io_di)
	);

	navre_checker u_checker (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .pmem_ce(pmem_ce), .pmem_a(pmem_a),
		.io_re(io_re), .io_we(io_we), .io_a(io_a), .io_do(io_do)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// Program word and I/O read data arrive one edge after the strobe.
	always @(negedge sys_clk) begin
		if (pmem_ce === 1'b1)
			pmem_d <= prog[pmem_a];
		if (io_re === 1'b1)
			io_di <= {2'b00, io_a} ^ 8'h5A;
	end

	// --------------------
	// Random source.
	// --------------------
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1); // Galois step.
		end
		return v;
	endfunction

	task automatic emit(input logic [15:0] w);
		prog[prog_len] = w;
		u_checker.load_word(prog_len, w);
		prog_len++;
	endtask

	// AVR encodings.
	function automatic logic [15:0] alu_word(input logic [5:0] op6, input logic [4:0] d,
	                                         input logic [4:0] r);
		return {op6, r[4], d, r[3:0]};
	endfunction
	function automatic logic [15:0] ldi_word(input logic [4:0] d, input logic [7:0] k);
		return {4'hE, k[7:4], d[3:0], k[3:0]};
	endfunction
	function automatic logic [15:0] io_word(input logic is_out, input logic [4:0] d,
	                                        input logic [5:0] a);
		return {4'b1011, is_out, a[5:4], d, a[3:0]};
	endfunction

	// --------------------
	// Program generator.
	// --------------------
	task automatic body_insn(input int mode, input int body_end);
		int          kind;
		int          k;
		logic [4:0]  d;
		logic [4:0]  r;
		int          flag_kinds [0:5]; // ADD, SUB, ADC, branch, OUT and LDI.
		kind = 0;
		flag_kinds = '{2, 3, 7, 8, 9, 0};
		d = 5'(rand_bits(5) % 30); // r30 and r31 stay the pointer.
		r = 5'(rand_bits(5));
		k = rand_bits(2) + 1;
		if (prog_len + 1 + k > body_end)
			k = (body_end - prog_len - 1 < 0) ? 0 : body_end - prog_len - 1; // Stay forward.
		case (mode)
			1: kind = rand_bits(3) % 7;
			2: kind = flag_kinds[rand_bits(3) % 6];
			default: kind = rand_bits(4) % 15;
		endcase
		case (kind)
			0: emit(ldi_word(5'(16 + rand_bits(4) % 14), 8'(rand_bits(8))));
			1: emit(alu_word(6'b001011, d, r)); // MOV.
			2: emit(alu_word(6'b000011, d, r)); // ADD.
			3: emit(alu_word(6'b000110, d, r)); // SUB.
			4: emit(alu_word(6'b001000, d, r)); // AND.
			5: emit(alu_word(6'b001010, d, r)); // OR.
			6: emit(alu_word(6'b001001, d, r)); // EOR.
			7: emit(alu_word(6'b000111, d, r)); // ADC.
			8: emit({5'b11110, rand_bits(1) == 1, 7'(k), 3'b001}); // BREQ or BRNE.
			9: emit(io_word(1'b1, r, 6'(rand_bits(6))));
			10: emit({4'hC, 12'(k)});
			11, 12: begin
				emit(ldi_word(5'd30, 8'(rand_bits(2)))); // One of four stored bytes.
				emit({6'b100000, kind == 12, d, 4'h0});
			end
			13: emit(io_word(1'b0, d, 6'(rand_bits(6))));
			default: emit(16'h0000);
		endcase
	endtask

	task automatic build_program(input int mode, input int n);
		int body_start;
		prog_len = 0;
		for (int i = 0; i < 1024; i++)
			emit({6'b000000, 10'(i)}); // NOP-class filler that differs per address.
		prog_len = 0;
		for (int i = 16; i < 30; i++)
			emit(ldi_word(5'(i), 8'(rand_bits(8))));
		emit(ldi_word(5'd31, 8'h01)); // Z = 0x100.
		for (int i = 0; i < 16; i++)
			emit(alu_word(6'b001011, 5'(i), 5'(16 + rand_bits(4) % 14)));
		for (int i = 0; i < 4; i++) begin
			emit(ldi_word(5'd30, 8'(i)));
			emit({7'b1000001, 5'(16 + i), 4'h0}); // Seed the bytes used later.
		end
		body_start = prog_len;
		if (mode == 3) begin
			for (int i = 0; i < 8; i++) begin
				st_addr[i] = 10'(rand_bits(10));
				emit(ldi_word(5'd31, {6'd0, st_addr[i][9:8]}));
				emit(ldi_word(5'd30, st_addr[i][7:0]));
				emit({7'b1000001, 5'(rand_bits(5) % 30), 4'h0});
			end
			for (int i = 0; i < 8; i++) begin
				emit(ldi_word(5'd31, {6'd0, st_addr[i][9:8]}));
				emit(ldi_word(5'd30, st_addr[i][7:0]));
				emit({7'b1000000, 5'(16 + rand_bits(4) % 14), 4'h0});
			end
		end else if (mode == 4) begin
			for (int i = 16; i < 30; i++)
				emit(io_word(1'b0, 5'(i), 6'(rand_bits(6))));
		end else begin
			for (int i = 0; i < n; i++)
				body_insn(mode, body_start + n);
		end
		for (int i = 16; i < 32; i++)
			emit(io_word(1'b1, 5'(i), 6'(i))); // Register dump.
		emit(16'hCFFF); // RJMP to itself.
	endtask

	// --------------------
	// Test sequence.
	// --------------------
	task automatic run_test(input string name, input int mode, input int n);
		int expected;
		int cycles;
		@(negedge sys_clk);
		sys_rst = 1'b0;
		build_program(mode, n);
		u_checker.start_test(name, expected);
		repeat (16) @(negedge sys_clk);
		sys_rst = 1'b1;
		cycles = 0;
		while (u_checker.write_count < expected && cycles < 5000) begin
			@(negedge sys_clk);
			cycles++;
		end
		if (u_checker.write_count < expected)
			$display("%s: timed out after %0d of %0d I/O writes", name,
			         u_checker.write_count, expected);
		u_checker.end_test(u_checker.write_count < expected);
	endtask

	initial begin
		sys_rst = 1'b0;
		pmem_d  = 16'h0000;
		io_di   = 8'h00;
		lfsr    = 16'd84;
		run_test("reset", 1, 0);
		run_test("alu", 1, 40);
		run_test("flags", 2, 60);
		run_test("dmem", 3, 0);
		run_test("io_read", 4, 0);
		run_test("mixed", 5, 200);
		u_checker.final_report();
		if (u_checker.fail_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
hw/navre_pkg.sv
hw/navre_alu.sv
hw/navre_decode.sv
hw/navre_core.sv
hw/navre_dmem.sv
hw/navre_system.sv
test/navre_checker.sv
test/tb_navre.sv

/* Makefile */
# Verilator flow for the navre regression.

TOP := tb_navre

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
